// ==== src/render_pkg.sv ====
package render_pkg;

  // Screen position, as counted by the video timing.
  typedef logic [10:0] hcount_t;
  typedef logic [9:0]  vcount_t;

  typedef struct packed {
    hcount_t h;
    vcount_t v;
  } pixel_coord_t;

  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } rgb_t;

  // One shaded pixel, tagged with the position it belongs to.
  typedef struct packed {
    pixel_coord_t coord;
    rgb_t         color;
  } pixel_out_t;

endpackage

// ==== src/scene_pkg.sv ====
package scene_pkg;

  typedef logic signed [11:0] offset_t;   // Screen position minus sphere centre.
  typedef logic [23:0]        dist2_t;    // Holds two squared offsets and their sum.
  typedef logic [7:0]         intensity_t;

  // Sphere seen along the view axis.
  typedef struct packed {
    render_pkg::hcount_t cx;
    render_pkg::vcount_t cy;
    dist2_t              radius2;
    render_pkg::rgb_t    color;
  } sphere_t;

  // Orthographic ray, carrying its pixel position along with it.
  typedef struct packed {
    render_pkg::pixel_coord_t coord;
    offset_t                  dx;
    offset_t                  dy;
  } ray_t;

endpackage

// ==== src/ray_gen.sv ====
`timescale 1ns/100ps

module ray_gen (
  input  logic                     aclk,
  input  logic                     arst_n,
  input  scene_pkg::sphere_t       sphere,
  input  render_pkg::pixel_coord_t coord_data,
  input  logic                     coord_valid,
  output logic                     coord_ready,
  output scene_pkg::ray_t          ray,
  output logic                     ray_valid,
  input  logic                     ray_ready
);
  import scene_pkg::*;

  offset_t dx;
  offset_t dy;
  logic    coord_fire;

  // Take a new coordinate when the register is empty or being drained.
  assign coord_ready = !ray_valid || ray_ready;
  assign coord_fire  = coord_valid && coord_ready;

  // Both operands are unsigned, so they get a zero sign bit first.
  assign dx = offset_t'({1'b0, coord_data.h}) - offset_t'({1'b0, sphere.cx});
  assign dy = offset_t'({2'b00, coord_data.v}) - offset_t'({2'b00, sphere.cy});

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      ray_valid <= 1'b0;
    end else if (coord_fire) begin
      ray_valid <= 1'b1;
    end else if (ray_ready) begin
      ray_valid <= 1'b0;                 // Drained with nothing behind it.
    end
  end

  always_ff @(posedge aclk) begin
    if (coord_fire) begin
      ray <= '{coord: coord_data, dx: dx, dy: dy};
    end
  end

  // A stalled ray keeps its valid and its content until the FIFO takes it.
  a_ray_stable: assert property (
    @(posedge aclk) disable iff (!arst_n)
    ray_valid && !ray_ready |=> ray_valid && $stable(ray)
  );

endmodule

// ==== src/ray_fifo.sv ====
`timescale 1ns/100ps

module ray_fifo #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic            aclk,
  input  logic            arst_n,
  input  scene_pkg::ray_t in_ray,
  input  logic            in_valid,
  output logic            in_ready,
  output scene_pkg::ray_t out_ray,
  output logic            out_valid,
  input  logic            out_ready
);
  import scene_pkg::*;

  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int CNT_W = PTR_W + 1;
  localparam logic [CNT_W-1:0] FULL_COUNT = CNT_W'(FIFO_DEPTH);

  ray_t             mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             wr_pend;   // Last written entry, not yet shown.
  logic             full;
  logic             in_fire;
  logic             out_fire;

  assign full     = (count == FULL_COUNT);
  assign in_ready = !full;
  assign in_fire  = in_valid && in_ready;

  // The newest word is held back one cycle before the reader can see it.
  assign out_valid = (count > CNT_W'(wr_pend));
  assign out_fire  = out_valid && out_ready;
  assign out_ray   = mem[rd_ptr];   // Head shown directly.

  always_ff @(posedge aclk) begin
    if (in_fire) begin
      mem[wr_ptr] <= in_ray;
    end
  end

  // Pointers wrap naturally since the depth is a power of two.
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      wr_pend <= 1'b0;
    end else begin
      wr_pend <= in_fire;
      if (in_fire) begin
        wr_ptr <= wr_ptr + PTR_W'(1);
      end
      if (out_fire) begin
        rd_ptr <= rd_ptr + PTR_W'(1);
      end
      case ({in_fire, out_fire})
        2'b10:   count <= count + CNT_W'(1);
        2'b01:   count <= count - CNT_W'(1);
        default: count <= count;
      endcase
    end
  end

  // A write never lands on an entry that still waits to be read.
  a_no_write_full: assert property (
    @(posedge aclk) disable iff (!arst_n)
    in_fire && (wr_ptr == rd_ptr) |-> (count == '0)
  );

  // A read never overtakes the write pointer.
  a_no_read_empty: assert property (
    @(posedge aclk) disable iff (!arst_n)
    out_fire |-> (rd_ptr != wr_ptr) || full
  );

endmodule

// ==== src/sphere_shader.sv ====
`timescale 1ns/100ps

module sphere_shader #(
  parameter int SHADE_SHIFT = 4
) (
  input  logic                   aclk,
  input  logic                   arst_n,
  input  scene_pkg::sphere_t     sphere,
  input  scene_pkg::ray_t        ray,
  input  logic                   ray_valid,
  output logic                   ray_ready,
  output render_pkg::pixel_out_t pixel_data,
  output logic                   pixel_valid,
  input  logic                   pixel_ready
);
  import render_pkg::*;
  import scene_pkg::*;

  logic               advance;
  logic signed [23:0] dx_sq;
  logic signed [23:0] dy_sq;
  logic               s1_valid;
  pixel_coord_t       s1_coord;
  dist2_t             s1_dx2;
  dist2_t             s1_dy2;
  dist2_t             d2;
  logic               hit;
  logic               s2_valid;
  pixel_coord_t       s2_coord;
  logic               s2_hit;
  dist2_t             s2_depth;
  dist2_t             shifted;
  intensity_t         level;
  rgb_t               shade;

  function automatic logic [7:0] scale_channel(input logic [7:0] ch, input intensity_t lvl);
    logic [15:0] prod;
    prod = 16'(ch) * 16'(lvl);
    return prod[15:8];
  endfunction

  // The whole pipe moves together and freezes when the output is stuck.
  assign advance   = !pixel_valid || pixel_ready;
  assign ray_ready = advance;

  // Stage 1 inputs.
  assign dx_sq = 24'($signed(ray.dx)) * 24'($signed(ray.dx));
  assign dy_sq = 24'($signed(ray.dy)) * 24'($signed(ray.dy));

  // Stage 2 inputs. The sum cannot overflow for 12-bit offsets.
  assign d2  = s1_dx2 + s1_dy2;
  assign hit = (d2 <= sphere.radius2);

  // Stage 3 inputs.
  assign shifted = s2_depth >> SHADE_SHIFT;
  assign level   = (shifted > dist2_t'(255)) ? '1 : intensity_t'(shifted);
  assign shade.r = scale_channel(sphere.color.r, level);
  assign shade.g = scale_channel(sphere.color.g, level);
  assign shade.b = scale_channel(sphere.color.b, level);

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      s1_valid    <= 1'b0;
      s2_valid    <= 1'b0;
      pixel_valid <= 1'b0;
    end else if (advance) begin
      s1_valid    <= ray_valid;
      s2_valid    <= s1_valid;
      pixel_valid <= s2_valid;
    end
  end

  always_ff @(posedge aclk) begin
    if (advance) begin
      s1_coord <= ray.coord;
      s1_dx2   <= dist2_t'(dx_sq);   // Squares are never negative.
      s1_dy2   <= dist2_t'(dy_sq);
      s2_coord <= s1_coord;
      s2_hit   <= hit;
      s2_depth <= sphere.radius2 - d2;   // Wraps on a miss and is blanked in stage 3.
      pixel_data.coord <= s2_coord;
      pixel_data.color <= s2_hit ? shade : '0;
    end
  end

  // Output holds still while the sink refuses it.
  a_pixel_stable: assert property (
    @(posedge aclk) disable iff (!arst_n)
    pixel_valid && !pixel_ready |=> pixel_valid && $stable(pixel_data)
  );

endmodule

// ==== src/renderer.sv ====
`timescale 1ns/100ps

module renderer #(
  parameter int FIFO_DEPTH  = 8,
  parameter int SHADE_SHIFT = 4
) (
  input  logic                     aclk,
  input  logic                     arst_n,
  input  scene_pkg::sphere_t       sphere,
  input  render_pkg::pixel_coord_t coord_data,
  input  logic                     coord_valid,
  output logic                     coord_ready,
  output render_pkg::pixel_out_t   pixel_data,
  output logic                     pixel_valid,
  input  logic                     pixel_ready
);
  import scene_pkg::*;

  ray_t gen_ray;
  logic gen_valid;
  logic gen_ready;
  ray_t buf_ray;
  logic buf_valid;
  logic buf_ready;

  ray_gen ray_gen0 (
    .aclk        (aclk),
    .arst_n      (arst_n),
    .sphere      (sphere),
    .coord_data  (coord_data),
    .coord_valid (coord_valid),
    .coord_ready (coord_ready),
    .ray         (gen_ray),
    .ray_valid   (gen_valid),
    .ray_ready   (gen_ready)
  );

  // Absorbs the shader stalls so the producer keeps running.
  ray_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) ray_fifo0 (
    .aclk      (aclk),
    .arst_n    (arst_n),
    .in_ray    (gen_ray),
    .in_valid  (gen_valid),
    .in_ready  (gen_ready),
    .out_ray   (buf_ray),
    .out_valid (buf_valid),
    .out_ready (buf_ready)
  );

  sphere_shader #(
    .SHADE_SHIFT (SHADE_SHIFT)
  ) sphere_shader0 (
    .aclk        (aclk),
    .arst_n      (arst_n),
    .sphere      (sphere),
    .ray         (buf_ray),
    .ray_valid   (buf_valid),
    .ray_ready   (buf_ready),
    .pixel_data  (pixel_data),
    .pixel_valid (pixel_valid),
    .pixel_ready (pixel_ready)
  );

endmodule

// ==== test/tb_renderer.sv ====
`timescale 1ns/100ps

module tb_renderer;
  import render_pkg::*;
  import scene_pkg::*;

  localparam int FIFO_DEPTH  = 8;
  localparam int SHADE_SHIFT = 4;

  logic         aclk;
  logic         arst_n;
  sphere_t      sphere;
  pixel_coord_t coord_data;
  logic         coord_valid;
  logic         coord_ready;
  pixel_out_t   pixel_data;
  logic         pixel_valid;
  logic         pixel_ready;

  pixel_out_t got_q[$];   // Pixels taken from the DUT.
  pixel_out_t exp_q[$];   // Pixels expected, in send order.
  int         errors;
  int         checks;
  int         tests_run;

  renderer #(
    .FIFO_DEPTH  (FIFO_DEPTH),
    .SHADE_SHIFT (SHADE_SHIFT)
  ) dut0 (
    .aclk        (aclk),
    .arst_n      (arst_n),
    .sphere      (sphere),
    .coord_data  (coord_data),
    .coord_valid (coord_valid),
    .coord_ready (coord_ready),
    .pixel_data  (pixel_data),
    .pixel_valid (pixel_valid),
    .pixel_ready (pixel_ready)
  );

  always #50 aclk = ~aclk;

  // Output sink, values seen just before the edge.
  always @(posedge aclk) begin
    if (arst_n && pixel_valid && pixel_ready) begin
      got_q.push_back(pixel_data);
    end
  end

  // Shading rule for one pixel, in plain integers.
  function automatic rgb_t expected_color(input sphere_t s, input pixel_coord_t c);
    int   dx;
    int   dy;
    int   d2;
    int   r2;
    int   level;
    rgb_t px;
    dx = int'(c.h) - int'(s.cx);
    dy = int'(c.v) - int'(s.cy);
    d2 = dx * dx + dy * dy;
    r2 = int'(s.radius2);
    px = '0;
    if (d2 <= r2) begin
      level = (r2 - d2) >> SHADE_SHIFT;
      if (level > 255) begin
        level = 255;
      end
      px.r = 8'((int'(s.color.r) * level) >> 8);
      px.g = 8'((int'(s.color.g) * level) >> 8);
      px.b = 8'((int'(s.color.b) * level) >> 8);
    end
    return px;
  endfunction

  function automatic sphere_t random_sphere();
    sphere_t     s;
    int          r;
    logic [23:0] col;
    r = int'($urandom_range(40, 10));
    col = 24'($urandom);
    s.cx = hcount_t'($urandom_range(540, 100));
    s.cy = vcount_t'($urandom_range(380, 100));
    s.radius2 = dist2_t'(r * r);
    s.color = col;
    return s;
  endfunction

  task automatic report_error(input string msg);
    $display("[ERROR] %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic report_timeout(input string what);
    $display("Timed out at %0t while waiting for %s.", $time, what);
    errors++;
  endtask

  task automatic check_pixel(input rgb_t got, input rgb_t exp, input string what);
    checks++;
    if (got !== exp) begin
      report_error($sformatf("%s colour %h, expected %h", what, got, exp));
    end
  endtask

  task automatic check_coord(input pixel_coord_t got, input pixel_coord_t exp, input string what);
    checks++;
    if (got !== exp) begin
      report_error($sformatf("%s %0d,%0d, expected %0d,%0d", what, got.h, got.v, exp.h, exp.v));
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      report_error($sformatf("%s is %b, expected %b", what, got, exp));
    end
  endtask

  task automatic set_sphere(input sphere_t s);
    sphere <= s;
    @(posedge aclk);
  endtask

  // Offers one coordinate and returns on the edge that takes it.
  task automatic send_coord(input pixel_coord_t c, input rgb_t color);
    int         waited;
    pixel_out_t p;
    waited = 0;
    coord_data  <= c;
    coord_valid <= 1'b1;
    @(posedge aclk);
    while (!coord_ready && waited < 200) begin
      @(posedge aclk);
      waited++;
    end
    if (!coord_ready) begin
      report_timeout("coord_ready");
      coord_valid <= 1'b0;
    end else begin
      p.coord = c;
      p.color = color;
      exp_q.push_back(p);
    end
  endtask

  task automatic drain_and_check(input int n);
    int         waited;
    pixel_out_t got;
    pixel_out_t exp;
    waited = 0;
    while (got_q.size() < n && waited < 1000) begin
      @(posedge aclk);
      waited++;
    end
    if (got_q.size() < n) begin
      report_timeout($sformatf("%0d pixels, %0d arrived", n, got_q.size()));
    end
    repeat (8) @(posedge aclk);   // Room for any stray extra pixel.
    if (got_q.size() != n) begin
      report_error($sformatf("%0d pixels received, expected %0d", got_q.size(), n));
    end
    while (got_q.size() > 0 && exp_q.size() > 0) begin
      got = got_q.pop_front();
      exp = exp_q.pop_front();
      check_coord(got.coord, exp.coord, "pixel position");
      check_pixel(got.color, exp.color, $sformatf("pixel %0d,%0d", exp.coord.h, exp.coord.v));
    end
    got_q.delete();
    exp_q.delete();
  endtask

  task automatic finish_test(input string name, input int mark);
    tests_run++;
    $display("test %-14s %s", name, (errors == mark) ? "passed" : "failed");
  endtask

  task automatic test_reset();
    arst_n <= 1'b0;
    for (int i = 0; i < 8; i++) begin
      @(posedge aclk);
      if (i > 0) begin   // Flops are reset by the first edge at the latest.
        check_bit(pixel_valid, 1'b0, "pixel_valid in reset");
        check_bit(coord_ready, 1'b1, "coord_ready in reset");
      end
    end
    arst_n <= 1'b1;
    @(posedge aclk);
    check_bit(pixel_valid, 1'b0, "pixel_valid after reset");
    check_bit(coord_ready, 1'b1, "coord_ready after reset");
  endtask

  task automatic test_latency();
    sphere_t      s;
    pixel_coord_t c;
    s.cx = 11'd320;
    s.cy = 10'd240;
    s.radius2 = 24'd3000;
    s.color = 24'hc89664;
    set_sphere(s);
    c.h = 11'd320;
    c.v = 10'd240;
    send_coord(c, expected_color(s, c));
    coord_valid <= 1'b0;
    // High after the fifth edge, so first seen on the sixth.
    for (int i = 1; i <= 6; i++) begin
      @(posedge aclk);
      check_bit(pixel_valid, i == 6, $sformatf("pixel_valid %0d edges after transfer", i));
    end
    drain_and_check(1);
  endtask

  task automatic test_hit_miss();
    int           off_x[8] = '{60, 60, 60, -60, 0, 0, 0, -100};
    int           off_y[8] = '{80, 79, 81, -79, 100, -99, 101, 0};
    sphere_t      s;
    pixel_coord_t c;
    s.cx = 11'd500;
    s.cy = 10'd300;
    s.radius2 = 24'd10000;
    s.color = 24'hf0b43c;
    set_sphere(s);
    for (int i = 0; i < 8; i++) begin
      c.h = hcount_t'(500 + off_x[i]);
      c.v = vcount_t'(300 + off_y[i]);
      send_coord(c, expected_color(s, c));
    end
    coord_valid <= 1'b0;
    drain_and_check(8);
  endtask

  task automatic test_stream();
    sphere_t      s;
    pixel_coord_t c;
    s = random_sphere();
    set_sphere(s);
    for (int i = 0; i < 64; i++) begin
      c.h = hcount_t'(int'(s.cx) - 32 + i);
      c.v = vcount_t'(int'(s.cy) + int'($urandom_range(40, 0)) - 20);
      send_coord(c, expected_color(s, c));
    end
    coord_valid <= 1'b0;
    drain_and_check(64);
  endtask

  task automatic test_backpressure();
    sphere_t      s;
    pixel_coord_t c;
    int           waited;
    int           sent;
    logic         stalled;
    s = random_sphere();
    set_sphere(s);
    fork
      begin
        for (int i = 0; i < 64; i++) begin
          c.h = hcount_t'(int'(s.cx) + int'($urandom_range(60, 0)) - 30);
          c.v = vcount_t'(int'(s.cy) + int'($urandom_range(60, 0)) - 30);
          send_coord(c, expected_color(s, c));
        end
        coord_valid <= 1'b0;
      end
      begin
        waited = 0;
        while (got_q.size() < 64 && waited < 3000) begin
          pixel_ready <= ($urandom_range(1, 0) == 1);
          @(posedge aclk);
          waited++;
        end
        pixel_ready <= 1'b1;
      end
    join
    drain_and_check(64);

    // Output stuck low until the input side refuses.
    pixel_ready <= 1'b0;
    c.h = s.cx;
    c.v = s.cy;
    coord_data  <= c;
    coord_valid <= 1'b1;
    sent = 0;
    stalled = 1'b0;
    while (!stalled && sent < 40) begin
      @(posedge aclk);
      if (coord_ready) begin
        exp_q.push_back(pixel_out_t'{coord: c, color: expected_color(s, c)});
        sent++;
        c.h = c.h + 11'd1;
        coord_data <= c;
      end else begin
        stalled = 1'b1;
      end
    end
    check_bit(stalled, 1'b1, "coord_ready drop under stall");
    pixel_ready <= 1'b1;
    send_coord(c, expected_color(s, c));   // The coordinate left waiting.
    coord_valid <= 1'b0;
    drain_and_check(sent + 1);
  endtask

  task automatic test_saturation();
    sphere_t      s;
    pixel_coord_t c;
    rgb_t         sat;
    s.cx = 11'd700;
    s.cy = 10'd400;
    s.radius2 = 24'd40000;
    s.color = 24'hff8007;
    set_sphere(s);
    sat = 24'hfe7f06;   // Each channel times 255, over 256.
    c.h = 11'd700;
    c.v = 10'd400;
    send_coord(c, sat);
    c.h = 11'd701;
    c.v = 10'd401;
    send_coord(c, sat);
    c.h = 11'd698;
    c.v = 10'd403;
    send_coord(c, sat);
    coord_valid <= 1'b0;
    drain_and_check(3);
  endtask

  initial begin
    int mark;
    void'($urandom(50651));
    aclk        = 1'b0;
    arst_n      = 1'b0;
    sphere      = '0;
    coord_data  = '0;
    coord_valid = 1'b0;
    pixel_ready = 1'b1;
    errors      = 0;
    checks      = 0;
    tests_run   = 0;

    mark = errors;
    test_reset();
    finish_test("reset", mark);
    mark = errors;
    test_latency();
    finish_test("latency", mark);
    mark = errors;
    test_hit_miss();
    finish_test("hit_miss", mark);
    mark = errors;
    test_stream();
    finish_test("stream", mark);
    mark = errors;
    test_backpressure();
    finish_test("backpressure", mark);
    mark = errors;
    test_saturation();
    finish_test("saturation", mark);

    $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
src/render_pkg.sv
src/scene_pkg.sv
src/ray_gen.sv
src/ray_fifo.sv
src/sphere_shader.sv
src/renderer.sv
test/tb_renderer.sv

// ==== Makefile ====
# Verilator flow for the sphere renderer.

VERILATOR ?= verilator
FILELIST  ?= filelist.f
TB_TOP    ?= tb_renderer
RTL_TOP   ?= renderer
OBJ_DIR   ?= obj_dir
SIM_FLAGS ?= --timing --assert
PASS_TEXT ?= Everything OK

RTL_SRCS = src/render_pkg.sv src/scene_pkg.sv src/ray_gen.sv \
           src/ray_fifo.sv src/sphere_shader.sv src/renderer.sv

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(RTL_SRCS) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

# Fails unless the run prints the pass text.
sim: build
	@out=$$(./$(OBJ_DIR)/V$(TB_TOP)); echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
